// File: branch_consts.svh
// Widths, table depth and memory map of the branch check unit, included by the package and RTL
`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

`define BR_PC_WIDTH       10
`define BR_WORD_WIDTH     16
`define BR_ADDR_WIDTH     10
`define BR_ENTRIES        4
`define BR_INDEX_WIDTH    2
`define BR_FLAGS_WIDTH    4
`define BR_COND_WIDTH     3
`define BR_TABLE_COUNT    5

// Table base addresses on the ALU write port
`define BR_ORIGIN_BASE    10'h200
`define BR_DEST_BASE      10'h204
`define BR_COND_BASE      10'h208
`define BR_PRED_BASE      10'h20C
`define BR_PE_BASE        10'h210

// Write enable bit positions
`define BR_WREN_ORIGIN    0
`define BR_WREN_DEST      1
`define BR_WREN_COND      2
`define BR_WREN_PRED      3
`define BR_WREN_PE        4

// Flag bit positions
`define BR_FLAG_ZERO      0
`define BR_FLAG_NEGATIVE  1
`define BR_FLAG_CARRY     2
`define BR_FLAG_OVERFLOW  3

// Condition codes
`define BR_COND_NEVER     3'd0
`define BR_COND_ALWAYS    3'd1
`define BR_COND_ZERO      3'd2
`define BR_COND_NOT_ZERO  3'd3
`define BR_COND_NEGATIVE  3'd4
`define BR_COND_POSITIVE  3'd5
`define BR_COND_CARRY     3'd6
`define BR_COND_NO_CARRY  3'd7

`endif

// File: branch_pkg.sv
// Vector types and packed structs shared by the branch check RTL and its testbench
`default_nettype none

`include "branch_consts.svh"

package branch_pkg;

    typedef logic [`BR_PC_WIDTH-1:0]    pc_t;
    typedef logic [`BR_WORD_WIDTH-1:0]  word_t;
    typedef logic [`BR_ADDR_WIDTH-1:0]  write_addr_t;
    typedef logic [`BR_INDEX_WIDTH-1:0] entry_idx_t;
    typedef logic [`BR_FLAGS_WIDTH-1:0] flags_t;
    typedef logic [`BR_COND_WIDTH-1:0]  cond_code_t;
    typedef logic [`BR_TABLE_COUNT-1:0] table_wren_t;  // Bit per table, origin at bit 0

    // ------------------------------
    // Decoded write command, one table at most per cycle
    typedef struct packed {
        table_wren_t wren;
        entry_idx_t  index;         // Zero based within the table
        pc_t         origin;
        pc_t         destination;
        cond_code_t  condition;
        logic        prediction;
        logic        pred_enable;
    } branch_write_t;

    // ------------------------------
    // One stored branch
    typedef struct packed {
        pc_t        origin;
        pc_t        destination;
        cond_code_t condition;
        logic       prediction;     // Predicted taken
        logic       pred_enable;    // Use prediction instead of condition
    } branch_entry_t;

endpackage

`default_nettype wire

// File: branch_write_decoder.sv
// Decodes ALU writes into per-table enables, zero-based index and sliced data for the branch table
`timescale 1ns/1ns
`default_nettype none

`include "branch_consts.svh"

module branch_write_decoder
    import branch_pkg::*;
(
    input  wire write_addr_t   write_addr,
    input  wire word_t         write_data,
    output branch_write_t      write_cmd
);

    // True when the address lies inside a table of BR_ENTRIES words at base
    function automatic logic in_table(input write_addr_t addr, input write_addr_t base);
        logic above;
        logic below;
        above = (addr >= base);
        below = (addr < (base + write_addr_t'(`BR_ENTRIES)));
        return above && below;
    endfunction

    // ------------------------------
    // Address decode

    logic hit_origin;
    logic hit_dest;
    logic hit_cond;
    logic hit_pred;
    logic hit_pe;

    always_comb begin
        hit_origin = in_table(write_addr, `BR_ORIGIN_BASE);
        hit_dest   = in_table(write_addr, `BR_DEST_BASE);
        hit_cond   = in_table(write_addr, `BR_COND_BASE);
        hit_pred   = in_table(write_addr, `BR_PRED_BASE);
        hit_pe     = in_table(write_addr, `BR_PE_BASE);
    end

    // ------------------------------
    // Address translation to a zero-based index

    write_addr_t offset;

    always_comb begin
        offset = '0;                                // Unmapped address, index unused
        if (hit_origin) offset = write_addr - `BR_ORIGIN_BASE;
        if (hit_dest)   offset = write_addr - `BR_DEST_BASE;
        if (hit_cond)   offset = write_addr - `BR_COND_BASE;
        if (hit_pred)   offset = write_addr - `BR_PRED_BASE;
        if (hit_pe)     offset = write_addr - `BR_PE_BASE;
    end

    // ------------------------------
    // Command assembly and data slices

    always_comb begin
        write_cmd = '0;
        write_cmd.wren[`BR_WREN_ORIGIN] = hit_origin;
        write_cmd.wren[`BR_WREN_DEST]   = hit_dest;
        write_cmd.wren[`BR_WREN_COND]   = hit_cond;
        write_cmd.wren[`BR_WREN_PRED]   = hit_pred;
        write_cmd.wren[`BR_WREN_PE]     = hit_pe;
        write_cmd.index       = entry_idx_t'(offset);
        write_cmd.origin      = write_data[`BR_PC_WIDTH-1:0];
        write_cmd.destination = write_data[`BR_PC_WIDTH-1:0];
        write_cmd.condition   = write_data[`BR_COND_WIDTH-1:0];
        write_cmd.prediction  = write_data[0];
        write_cmd.pred_enable = write_data[0];     // Same bit, other table
    end

endmodule

`default_nettype wire

// File: branch_table.sv
// Register file of branch entries, written by decoded commands and read in parallel by the evaluator
`timescale 1ns/1ns
`default_nettype none

`include "branch_consts.svh"

module branch_table
    import branch_pkg::*;
(
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  wire branch_write_t                    write_cmd,
    output branch_entry_t [`BR_ENTRIES-1:0]       entries
);

    // ------------------------------
    // Per-entry select from the command index

    logic [`BR_ENTRIES-1:0] entry_sel;

    always_comb begin
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            entry_sel[i] = (write_cmd.index == entry_idx_t'(i));
        end
    end

    // ------------------------------
    // Storage
    // Each field has its own enable, so one ALU word updates one table only

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entries <= '0;                          // Condition never, prediction off
        end else begin
            for (int i = 0; i < `BR_ENTRIES; i++) begin
                if (entry_sel[i]) begin
                    if (write_cmd.wren[`BR_WREN_ORIGIN]) begin
                        entries[i].origin <= write_cmd.origin;
                    end
                    if (write_cmd.wren[`BR_WREN_DEST]) begin
                        entries[i].destination <= write_cmd.destination;
                    end
                    if (write_cmd.wren[`BR_WREN_COND]) begin
                        entries[i].condition <= write_cmd.condition;
                    end
                    if (write_cmd.wren[`BR_WREN_PRED]) begin
                        entries[i].prediction <= write_cmd.prediction;
                    end
                    if (write_cmd.wren[`BR_WREN_PE]) begin
                        entries[i].pred_enable <= write_cmd.pred_enable;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: branch_evaluator.sv
// Matches the PC against stored origins and registers jump, cancel and branch destination
`timescale 1ns/1ns
`default_nettype none

`include "branch_consts.svh"

module branch_evaluator
    import branch_pkg::*;
(
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  wire branch_entry_t [`BR_ENTRIES-1:0]  entries,
    input  wire pc_t                              pc,
    input  wire flags_t                           flags,
    input  wire                                   io_ready_previous,
    output pc_t                                   branch_destination,
    output logic                                  jump,
    output logic                                  cancel
);

    // Condition code against the ALU flags
    function automatic logic cond_holds(input cond_code_t code, input flags_t f);
        logic zero;
        logic negative;
        logic carry;
        zero     = f[`BR_FLAG_ZERO];
        negative = f[`BR_FLAG_NEGATIVE];
        carry    = f[`BR_FLAG_CARRY];
        case (code)
            `BR_COND_NEVER:    return 1'b0;
            `BR_COND_ALWAYS:   return 1'b1;
            `BR_COND_ZERO:     return zero;
            `BR_COND_NOT_ZERO: return !zero;
            `BR_COND_NEGATIVE: return negative;
            `BR_COND_POSITIVE: return !zero && !negative;
            `BR_COND_CARRY:    return carry;
            default:           return !carry;      // No carry
        endcase
    endfunction

    // ------------------------------
    // Origin match, lowest index wins

    logic          match;
    branch_entry_t hit_entry;

    always_comb begin
        match     = 1'b0;
        hit_entry = '0;
        // Walk down so the lowest matching index is left standing
        for (int i = `BR_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].origin == pc) begin
                match     = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    // ------------------------------
    // Decision

    logic taken;
    logic active;
    logic jump_next;
    logic cancel_next;
    pc_t  dest_next;

    always_comb begin
        taken  = cond_holds(hit_entry.condition, flags);
        active = match && io_ready_previous;      // IO gate on the decision
        if (hit_entry.pred_enable) begin
            jump_next   = active && hit_entry.prediction;
            cancel_next = active && (hit_entry.prediction != taken);  // Mispredicted
        end else begin
            jump_next   = active && taken;
            cancel_next = 1'b0;
        end
        dest_next = match ? hit_entry.destination : '0;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            branch_destination <= '0;
            jump               <= 1'b0;
            cancel             <= 1'b0;
        end else begin
            branch_destination <= dest_next;
            jump               <= jump_next;
            cancel             <= cancel_next;
        end
    end

endmodule

`default_nettype wire

// File: branch_check_mapped.sv
// Memory-mapped branch check unit top level, connects write decoder, branch table and evaluator
`timescale 1ns/1ns
`default_nettype none

`include "branch_consts.svh"

module branch_check_mapped
    import branch_pkg::*;
(
    input  wire                clock,
    input  wire                rst_n,
    input  wire pc_t           pc,
    input  wire flags_t        flags,
    input  wire                io_ready_previous,
    input  wire write_addr_t   write_addr,
    input  wire word_t         write_data,
    output pc_t                branch_destination,
    output logic               jump,
    output logic               cancel
);

    branch_write_t                    write_cmd;   // Combinational from the decoder
    branch_entry_t [`BR_ENTRIES-1:0]  entries;

    // ------------------------------
    // Producer

    branch_write_decoder u_write_decoder (
        .write_addr         (write_addr),
        .write_data         (write_data),
        .write_cmd          (write_cmd)
    );

    // ------------------------------
    // Buffer

    branch_table u_branch_table (
        .clock              (clock),
        .rst_n              (rst_n),
        .write_cmd          (write_cmd),
        .entries            (entries)
    );

    // ------------------------------
    // Consumer

    branch_evaluator u_branch_evaluator (
        .clock              (clock),
        .rst_n              (rst_n),
        .entries            (entries),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .branch_destination (branch_destination),
        .jump               (jump),
        .cancel             (cancel)
    );

endmodule

`default_nettype wire

// File: branch_check_assertions.sv
// Concurrent checks on the branch check top level, attached to every instance through bind
`timescale 1ns/1ns
`default_nettype none

`include "branch_consts.svh"

module branch_check_assertions
    import branch_pkg::*;
(
    input  wire                                   clock,
    input  wire                                   rst_n,
    input  wire pc_t                              pc,
    input  wire                                   io_ready_previous,
    input  wire branch_write_t                    write_cmd,
    input  wire branch_entry_t [`BR_ENTRIES-1:0]  entries,
    input  wire                                   jump,
    input  wire                                   cancel
);

    logic found;
    logic pe_match;                                          // First matching entry predicts

    always_comb begin
        found    = 1'b0;
        pe_match = 1'b0;
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            if (!found && entries[i].origin == pc) begin
                found    = 1'b1;
                pe_match = entries[i].pred_enable;
            end
        end
    end

    // ------------------------------
    a_single_wren: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(write_cmd.wren))
        else $error("more than one table write enable active");

    a_io_gate: assert property (@(posedge clock) disable iff (!rst_n)
        !io_ready_previous |=> !jump && !cancel)
        else $error("jump or cancel raised while IO was not ready");

    a_cancel_cause: assert property (@(posedge clock) disable iff (!rst_n)
        cancel |-> $past(pe_match))
        else $error("cancel without a predicted origin match");

endmodule

bind branch_check_mapped branch_check_assertions u_assertions (
    .clock             (clock),
    .rst_n             (rst_n),
    .pc                (pc),
    .io_ready_previous (io_ready_previous),
    .write_cmd         (write_cmd),
    .entries           (entries),
    .jump              (jump),
    .cancel            (cancel)
);

`default_nettype wire

// File: tb_branch_check_mapped.sv
// Branch check unit testbench with LCG stimulus checked each cycle against a table model
`timescale 1ns/1ns
`default_nettype none

`include "branch_consts.svh"

module tb_branch_check_mapped
    import branch_pkg::*;
();

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 20;
    localparam int RANDOM_CYCLES = 400;
    localparam write_addr_t IDLE_ADDR = 10'h000;             // Outside every table
    localparam write_addr_t MAP_BASE  = `BR_ORIGIN_BASE;
    localparam write_addr_t MAP_END   = write_addr_t'(`BR_PE_BASE + `BR_ENTRIES);

    logic        clock;
    logic        rst_n;
    pc_t         pc;
    flags_t      flags;
    logic        io_ready_previous;
    write_addr_t write_addr;
    word_t       write_data;
    pc_t         branch_destination;
    logic        jump;
    logic        cancel;

    logic [31:0] rng_state;

    // ------------------------------
    // Reference model state
    pc_t        m_origin [`BR_ENTRIES];
    pc_t        m_dest   [`BR_ENTRIES];
    cond_code_t m_cond   [`BR_ENTRIES];
    logic       m_pred   [`BR_ENTRIES];
    logic       m_pe     [`BR_ENTRIES];

    logic exp_jump;                                          // Expected values wait one clock
    logic exp_cancel;
    pc_t  exp_dest;

    branch_check_mapped u_dut (
        .clock              (clock),
        .rst_n              (rst_n),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .write_addr         (write_addr),
        .write_data         (write_data),
        .branch_destination (branch_destination),
        .jump               (jump),
        .cancel             (cancel)
    );

    always #20 clock = ~clock;

    // ------------------------------
    // Random numbers
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic pc_t rand_pc();
        logic [31:0] r;
        r = lcg_next();
        return r[31:22];
    endfunction

    function automatic flags_t rand_flags();
        logic [31:0] r;
        r = lcg_next();
        return r[31:28];
    endfunction

    function automatic word_t rand_word();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];
    endfunction

    // Field bits from value and the rest random so slicing gets exercised
    function automatic word_t mix_data(input word_t value, input word_t mask);
        return (rand_word() & ~mask) | (value & mask);
    endfunction

    // ------------------------------
    // Model
    task automatic model_write(input write_addr_t addr, input word_t data);
        write_addr_t rel;
        int          tbl;
        int          idx;
        rel = addr - MAP_BASE;
        if (addr >= MAP_BASE && addr < MAP_END) begin
            tbl = int'(rel[4:2]);                            // Tables of four words placed back to back
            idx = int'(rel[1:0]);
            case (tbl)
                0: m_origin[idx] = data[9:0];
                1: m_dest[idx]   = data[9:0];
                2: m_cond[idx]   = data[2:0];
                3: m_pred[idx]   = data[0];
                default: m_pe[idx] = data[0];
            endcase
        end
    endtask

    task automatic model_predict(input pc_t p, input flags_t f, input logic io);
        logic       found;
        int         hit;
        logic [7:0] cond_table;
        logic       taken;
        found = 1'b0;
        hit   = 0;
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            if (!found && m_origin[i] == p) begin
                found = 1'b1;
                hit   = i;
            end
        end
        // Bit n is the outcome of condition code n
        cond_table = {!f[2], f[2], !f[0] && !f[1], f[1], !f[0], f[0], 1'b1, 1'b0};
        taken      = cond_table[m_cond[hit]];
        exp_dest   = found ? m_dest[hit] : '0;
        if (found && io && m_pe[hit]) begin
            exp_jump   = m_pred[hit];
            exp_cancel = m_pred[hit] != taken;
        end else begin
            exp_jump   = found && io && taken;
            exp_cancel = 1'b0;
        end
    endtask

    // ------------------------------
    // Checking and stimulus
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s dut=%0h model=%0h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic drive_cycle(input pc_t p, input flags_t f, input logic io,
                               input write_addr_t addr, input word_t data);
        @(posedge clock);
        pc                <= p;
        flags             <= f;
        io_ready_previous <= io;
        write_addr        <= addr;
        write_data        <= data;
        @(negedge clock);                                    // Outputs settled from last edge
        check_value(32'(jump), 32'(exp_jump), "jump");
        check_value(32'(cancel), 32'(exp_cancel), "cancel");
        check_value(32'(branch_destination), 32'(exp_dest), "branch_destination");
        model_predict(p, f, io);
        model_write(addr, data);
    endtask

    task automatic check_pc(input pc_t p, input flags_t f, input logic io);
        drive_cycle(p, f, io, IDLE_ADDR, rand_word());
    endtask

    task automatic write_field(input write_addr_t base, input entry_idx_t idx,
                               input word_t value, input word_t mask);
        drive_cycle(rand_pc(), rand_flags(), 1'b1, base + write_addr_t'(idx),
                    mix_data(value, mask));
    endtask

    task automatic write_entry(input entry_idx_t idx, input pc_t origin, input pc_t dest,
                               input cond_code_t cond, input logic pred, input logic pe);
        write_field(`BR_ORIGIN_BASE, idx, word_t'(origin), 16'h03FF);
        write_field(`BR_DEST_BASE, idx, word_t'(dest), 16'h03FF);
        write_field(`BR_COND_BASE, idx, word_t'(cond), 16'h0007);
        write_field(`BR_PRED_BASE, idx, word_t'(pred), 16'h0001);
        write_field(`BR_PE_BASE, idx, word_t'(pe), 16'h0001);
    endtask

    initial begin
        int          wait_cycles;
        logic [31:0] r;
        write_addr_t addr;
        pc_t         p;
        entry_idx_t  idx;
        rng_state         = 32'h5511b671;
        clock             = 1'b0;
        rst_n             = 1'b0;
        pc                = '0;
        flags             = '0;
        io_ready_previous = 1'b0;
        write_addr        = IDLE_ADDR;
        write_data        = '0;
        exp_jump          = 1'b0;
        exp_cancel        = 1'b0;
        exp_dest          = '0;
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            m_origin[i] = '0;
            m_dest[i]   = '0;
            m_cond[i]   = '0;
            m_pred[i]   = 1'b0;
            m_pe[i]     = 1'b0;
        end

        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            if (wait_cycles >= RESET_TIMEOUT) begin
                abort_run("reset release was not seen within the reset timeout");
            end else begin
                @(posedge clock);
                wait_cycles++;
            end
        end

        // Fresh out of reset
        repeat (8) check_pc(rand_pc(), rand_flags(), 1'b1);

        // Fill every table and then poke addresses around the map
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            r = lcg_next();
            write_entry(entry_idx_t'(i), pc_t'(10'h0A0 + 3 * i), rand_pc(), r[2:0], r[3], 1'b0);
        end
        drive_cycle(rand_pc(), rand_flags(), 1'b1, 10'h1FF, rand_word());
        drive_cycle(rand_pc(), rand_flags(), 1'b1, 10'h214, rand_word());
        drive_cycle(rand_pc(), rand_flags(), 1'b1, 10'h21C, rand_word());
        drive_cycle(rand_pc(), rand_flags(), 1'b1, 10'h3FF, rand_word());
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            check_pc(m_origin[i], rand_flags(), 1'b1);
        end

        // All eight condition codes with prediction off
        for (int code = 0; code < 8; code++) begin
            idx = entry_idx_t'(code % 4);
            write_field(`BR_COND_BASE, idx, word_t'(code), 16'h0007);
            repeat (4) check_pc(m_origin[idx], rand_flags(), 1'b1);
        end

        // Prediction on with random prediction bit and condition
        for (int i = 0; i < `BR_ENTRIES; i++) begin
            r = lcg_next();
            write_field(`BR_PRED_BASE, entry_idx_t'(i), word_t'(r[31]), 16'h0001);
            write_field(`BR_COND_BASE, entry_idx_t'(i), word_t'(r[30:28]), 16'h0007);
            write_field(`BR_PE_BASE, entry_idx_t'(i), 16'h0001, 16'h0001);
            repeat (6) check_pc(m_origin[i], rand_flags(), 1'b1);
        end

        // Shared origin where the lowest index must win
        for (int i = 3; i >= 0; i--) begin
            write_field(`BR_ORIGIN_BASE, entry_idx_t'(i), 16'h0155, 16'h03FF);
            repeat (3) check_pc(10'h155, rand_flags(), 1'b1);
        end
        repeat (3) check_pc(10'h3FF, rand_flags(), 1'b1);    // No origin there

        // ------------------------------
        // Mixed random traffic
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = lcg_next();
            case (r[31:30])
                2'd0, 2'd1: addr = write_addr_t'(int'(MAP_BASE) + int'(r[20:16]) % 20);
                2'd2:       addr = r[9:0];
                default:    addr = IDLE_ADDR;
            endcase
            p = r[29] ? m_origin[r[15:14]] : rand_pc();
            drive_cycle(p, r[27:24], r[13:12] != 2'b00, addr, rand_word());
        end
        check_pc(10'h3FF, 4'h0, 1'b0);                       // Drains the last expected result

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: branch_check_mapped.f
+incdir+.
branch_pkg.sv
branch_write_decoder.sv
branch_table.sv
branch_evaluator.sv
branch_check_mapped.sv
branch_check_assertions.sv
tb_branch_check_mapped.sv

// File: Makefile
# Verilator build and run of the branch check testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_check_mapped
FILELIST  ?= branch_check_mapped.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := branch_consts.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
